// File: dv/axis_axi_write_golden.txt
# addr(hex) length max_len first_word(hex) mode bursts(0 = unchecked) checksum(hex)
# mode 0 preloads the stream, 1 adds stream gaps, 2 stalls AWREADY and WREADY
00000100 18 16 00001000 0 2 00012099
00000200 7 4 a0000000 0 2 60000015
00000300 16 16 00000055 0 1 000005c8
00000400 40 8 00000001 1 0 00000334
00000600 50 16 00020000 2 0 006404c9
00000800 1 1 deadbeef 0 1 deadbeef
00000900 33 5 00000010 1 0 00000420

// File: files.f
src/axi_bus_pkg.sv
src/wdma_ctrl_pkg.sv
src/burst_cmd_if.sv
src/axis_fifo.sv
src/fifo_to_axis.sv
src/axi_burst_writer.sv
src/axis_axi_write.sv
src/axis_axi_write_top.sv
dv/axis_axi_write_properties.sv
dv/tb_axis_axi_write.sv

// File: Makefile
TOOL  = verilator
FLAGS = --binary --timing --assert -Wno-fatal
TOP   = tb_axis_axi_write
FLIST = files.f
LOG   = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: dv/tb_axis_axi_write.sv
// ==================================================
// Golden-file driven test, slave memory covers 4 KB
// Mode 0 preloads the stream, 1 gaps it, 2 stalls AXI
// ==================================================
`timescale 1ns/1ps
`default_nettype none

module tb_axis_axi_write;

   logic clk_i, reset_i, start_i, tvalid, tready, busy_o;
   logic [31:0] addr_i, tdata, awaddr, wdata;
   logic [11:0] length_i, remaining_o;
   logic [4:0]  max_len_i;
   logic [7:0]  awlen;
   logic [2:0]  awsize;
   logic [1:0]  awburst;
   logic [3:0]  wstrb;
   logic awvalid, awready, wvalid, wready, wlast, bvalid, bready;
   logic [31:0] mem [0:1023];
   logic [31:0] aw_addr_q[$];
   int          aw_len_q[$];
   integer      seed = 65;
   int          errors = 0;
   int          mode = 0;
   logic        saw_full = 1'b0;
   logic        halted = 1'b0;

   axis_axi_write_top axis_axi_write_top_i (
      .clk_i(clk_i), .reset_i(reset_i), .start_i(start_i), .addr_i(addr_i),
      .length_i(length_i), .max_len_i(max_len_i), .busy_o(busy_o),
      .remaining_o(remaining_o), .s_axis_tdata_i(tdata), .s_axis_tvalid_i(tvalid),
      .s_axis_tready_o(tready), .awaddr_o(awaddr), .awlen_o(awlen), .awsize_o(awsize),
      .awburst_o(awburst), .awvalid_o(awvalid), .awready_i(awready), .wdata_o(wdata),
      .wstrb_o(wstrb), .wlast_o(wlast), .wvalid_o(wvalid), .wready_i(wready),
      .bresp_i(2'b00), .bvalid_i(bvalid), .bready_o(bready)
   );

   initial begin
      clk_i = 1'b0;
      forever #5 clk_i = ~clk_i;
   end

   task automatic report_mismatch(input string name, input logic [31:0] got,
                                  input logic [31:0] exp);
      errors++;
      $display("** Error @%0t: %s = %h, expected %h", $time, name, got, exp);
   endtask

   task automatic flag_timeout(input string what);
      errors++;
      halted = 1'b1;
      $display("Timeout at %0t: %s", $time, what);
   endtask

   // Handshakes are sampled at the falling edge, inputs move 1 ns after the rising edge
   task automatic send_stream(input int n, input logic [31:0] first);
      int idx;
      int wait_cnt;
      idx = 0;
      wait_cnt = 0;
      while (idx < n && !halted) begin
         @(posedge clk_i);
         #1;
         tvalid = (mode == 1) ? (($random(seed) % 3) != 0) : 1'b1;
         tdata  = first + idx;
         @(negedge clk_i);
         if (tvalid && tready) idx++;
         wait_cnt++;
         if (wait_cnt > 20000) flag_timeout("stream words not accepted");
      end
      @(posedge clk_i);
      #1;
      tvalid = 1'b0;
   endtask

   // AXI slave memory with random ready
   initial begin : slave
      logic [31:0] wr_addr;
      logic        b_set;
      logic        b_clr;
      for (int i = 0; i < 1024; i++) mem[i] = 32'hF000_0000 ^ (i << 2);
      awready = 1'b0;
      wready  = 1'b0;
      bvalid  = 1'b0;
      wr_addr = '0;
      forever begin
         @(negedge clk_i);
         b_set = 1'b0;
         b_clr = bvalid && bready;
         if (!tready && mode == 2) saw_full = 1'b1;
         if (awvalid && awready) begin
            // 4-byte INCR beats only
            if (awsize !== 3'b010) report_mismatch("awsize_o", awsize, 3'b010);
            if (awburst !== 2'b01) report_mismatch("awburst_o", awburst, 2'b01);
            aw_addr_q.push_back(awaddr);
            aw_len_q.push_back(int'(awlen) + 1);
            wr_addr = awaddr;
         end
         if (wvalid && wready) begin
            if (wstrb !== 4'hF) report_mismatch("wstrb_o", wstrb, 4'hF);
            mem[wr_addr[11:2]] = wdata;
            wr_addr = wr_addr + 4;
            b_set = wlast;
         end
         @(posedge clk_i);
         #1;
         awready = (mode == 2) ? (($random(seed) & 3) == 0) : (($random(seed) & 3) != 0);
         wready  = (mode == 2) ? (($random(seed) & 3) == 0) : (($random(seed) & 3) != 0);
         if (b_set) bvalid = 1'b1;
         else if (b_clr) bvalid = 1'b0;
      end
   end

   initial begin : main
      int fd, r, len, mlen, nb, exp_nb, sum_len, cnt, exp_len;
      logic [31:0] a, first, exp_sum, sum, next_addr;
      string line;
      reset_i = 1'b1;
      start_i = 1'b0;
      addr_i = '0;
      length_i = '0;
      max_len_i = '0;
      tvalid = 1'b0;
      tdata = '0;
      repeat (4) @(posedge clk_i);
      #1;
      reset_i = 1'b0;
      @(negedge clk_i);
      if (busy_o !== 1'b0) report_mismatch("busy_o", busy_o, 0);
      if (remaining_o !== 12'd0) report_mismatch("remaining_o", remaining_o, 0);
      if (awvalid !== 1'b0) report_mismatch("awvalid_o", awvalid, 0);
      if (wvalid !== 1'b0) report_mismatch("wvalid_o", wvalid, 0);
      if (bready !== 1'b0) report_mismatch("bready_o", bready, 0);
      fd = $fopen("dv/axis_axi_write_golden.txt", "r");
      if (fd == 0) begin
         errors++;
         $display("Golden file dv/axis_axi_write_golden.txt could not be opened");
      end
      while (fd != 0 && !halted && $fgets(line, fd) != 0) begin
         r = $sscanf(line, "%h %d %d %h %d %d %h", a, len, mlen, first, mode, exp_nb, exp_sum);
         if (r != 7) continue;
         aw_addr_q.delete();
         aw_len_q.delete();
         if (mode == 0) send_stream(len, first);
         @(posedge clk_i);
         #1;
         addr_i = a;
         length_i = 12'(len);
         max_len_i = 5'(mlen);
         start_i = 1'b1;
         @(posedge clk_i);
         #1;
         start_i = 1'b0;
         @(negedge clk_i);
         if (remaining_o !== 12'(len)) report_mismatch("remaining_o", remaining_o, len);
         if (mode == 1) begin
            // Stray start during a transfer, must leave 0xE00 and the burst size untouched
            @(posedge clk_i);
            #1;
            addr_i = 32'hE00;
            length_i = 12'd4;
            max_len_i = 5'd16;
            start_i = 1'b1;
            @(posedge clk_i);
            #1;
            start_i = 1'b0;
         end
         if (mode != 0) send_stream(len, first);
         cnt = 0;
         do begin
            @(negedge clk_i);
            cnt++;
            if (cnt > 20000) flag_timeout("busy_o never fell");
         end while (busy_o && !halted);
         if (remaining_o !== 12'd0) report_mismatch("remaining_o", remaining_o, 0);
         sum = '0;
         for (int i = 0; i < len; i++) begin
            sum = sum + mem[a[11:2] + i];
            if (mem[a[11:2] + i] !== first + i)
               report_mismatch("mem word", mem[a[11:2] + i], first + i);
         end
         if (sum !== exp_sum) report_mismatch("checksum", sum, exp_sum);
         if (mem[a[11:2] - 1] !== (32'hF000_0000 ^ (a - 4)))
            report_mismatch("mem below range", mem[a[11:2] - 1], 32'hF000_0000 ^ (a - 4));
         if (mem[a[11:2] + len] !== (32'hF000_0000 ^ (a + 4 * len)))
            report_mismatch("mem above range", mem[a[11:2] + len],
                            32'hF000_0000 ^ (a + 4 * len));
         nb = aw_len_q.size();
         if (exp_nb != 0 && nb != exp_nb) report_mismatch("burst count", nb, exp_nb);
         sum_len = 0;
         next_addr = a;
         for (int i = 0; i < nb; i++) begin
            if (aw_len_q[i] < 1 || aw_len_q[i] > mlen)
               report_mismatch("burst length", aw_len_q[i], mlen);
            // Preloaded data gives full bursts, then the tail
            exp_len = (len - sum_len < mlen) ? len - sum_len : mlen;
            if (mode == 0 && aw_len_q[i] != exp_len)
               report_mismatch("burst length", aw_len_q[i], exp_len);
            if (aw_addr_q[i] !== next_addr) report_mismatch("awaddr", aw_addr_q[i], next_addr);
            next_addr = aw_addr_q[i] + 4 * aw_len_q[i];
            sum_len += aw_len_q[i];
         end
         if (sum_len != len) report_mismatch("burst length sum", sum_len, len);
      end
      if (fd != 0) $fclose(fd);
      for (int i = 0; i < 4; i++) begin
         if (mem[896 + i] !== (32'hF000_0000 ^ (32'hE00 + 4 * i)))
            report_mismatch("mem at stray start", mem[896 + i],
                            32'hF000_0000 ^ (32'hE00 + 4 * i));
      end
      if (!saw_full) begin
         errors++;
         $display("Stream ready never dropped while AXI ready was stalled");
      end
      $display("Checks done with %0d errors", errors);
      if (errors == 0) begin
         $display("TEST RESULT: PASS");
      end else begin
         $display("TEST RESULT: FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: dv/axis_axi_write_properties.sv
// ==================================================
// AXI write channel rules, bound to the burst writer
// ==================================================
`timescale 1ns/1ps
`default_nettype none

module axis_axi_write_properties (
   input wire logic       clk_i,
   input wire logic       reset_i,
   input wire logic       awvalid_i,
   input wire logic       awready_i,
   input wire logic [7:0] awlen_i,
   input wire logic       wvalid_i,
   input wire logic       wready_i,
   input wire logic       wlast_i,
   input wire logic       start_i,
   input wire logic       busy_i
);

   logic [7:0] beat_q;
   logic [7:0] len_q;

   // Beat index within the current burst
   always_ff @(posedge clk_i) begin
      if (reset_i || (awvalid_i && awready_i)) begin
         beat_q <= '0;
      end else if (wvalid_i && wready_i) begin
         beat_q <= beat_q + 1'b1;
      end
      if (awvalid_i && awready_i) begin
         len_q <= awlen_i;
      end
   end

   aw_hold: assert property (@(posedge clk_i) disable iff (reset_i)
      awvalid_i && !awready_i |=> awvalid_i)
      else $error("AWVALID dropped before AWREADY");

   w_hold: assert property (@(posedge clk_i) disable iff (reset_i)
      wvalid_i && !wready_i |=> wvalid_i)
      else $error("WVALID dropped before WREADY");

   w_last: assert property (@(posedge clk_i) disable iff (reset_i)
      wvalid_i && wready_i |-> (wlast_i == (beat_q == len_q)))
      else $error("WLAST not on beat AWLEN+1");

   no_start_busy: assert property (@(posedge clk_i) disable iff (reset_i)
      !(start_i && busy_i))
      else $error("Burst start while writer busy");

endmodule

bind axi_burst_writer axis_axi_write_properties props_i (
   .clk_i     (clk_i),
   .reset_i   (reset_i),
   .awvalid_i (awvalid_o),
   .awready_i (awready_i),
   .awlen_i   (awlen_o),
   .wvalid_i  (wvalid_o),
   .wready_i  (wready_i),
   .wlast_i   (wlast_o),
   .start_i   (cmd.start),
   .busy_i    (cmd.busy)
);

`default_nettype wire

// File: src/axis_axi_write_top.sv
// ==================================================
// AXI-Stream to AXI4 write DMA, 32-bit words
// start_i is honored only while busy_o is low
// ==================================================
`timescale 1ns/1ps
`default_nettype none

module axis_axi_write_top (
   input  wire logic                       clk_i,
   input  wire logic                       reset_i,
   input  wire logic                       start_i,
   input  wire axi_bus_pkg::addr_t         addr_i,
   input  wire wdma_ctrl_pkg::wlen_t       length_i,
   input  wire axi_bus_pkg::burst_len_t    max_len_i,
   output logic                            busy_o,
   output wdma_ctrl_pkg::wlen_t            remaining_o,
   input  wire axi_bus_pkg::data_t         s_axis_tdata_i,
   input  wire logic                       s_axis_tvalid_i,
   output logic                            s_axis_tready_o,
   output axi_bus_pkg::addr_t              awaddr_o,
   output axi_bus_pkg::axi_len_t           awlen_o,
   output axi_bus_pkg::axi_size_t          awsize_o,
   output axi_bus_pkg::axi_burst_t         awburst_o,
   output logic                            awvalid_o,
   input  wire logic                       awready_i,
   output axi_bus_pkg::data_t              wdata_o,
   output axi_bus_pkg::strb_t              wstrb_o,
   output logic                            wlast_o,
   output logic                            wvalid_o,
   input  wire logic                       wready_i,
   input  wire axi_bus_pkg::axi_resp_t     bresp_i,
   input  wire logic                       bvalid_i,
   output logic                            bready_o
);

   logic               wr_tvalid;
   axi_bus_pkg::data_t wr_tdata;
   logic               wr_tready;

   burst_cmd_if cmd_if (.clk_i(clk_i));

   axis_axi_write planner_i (
      .clk_i           (clk_i),
      .reset_i         (reset_i),
      .start_i         (start_i),
      .addr_i          (addr_i),
      .length_i        (length_i),
      .max_len_i       (max_len_i),
      .busy_o          (busy_o),
      .remaining_o     (remaining_o),
      .s_axis_tdata_i  (s_axis_tdata_i),
      .s_axis_tvalid_i (s_axis_tvalid_i),
      .s_axis_tready_o (s_axis_tready_o),
      .cmd             (cmd_if.planner),
      .s_tvalid_o      (wr_tvalid),
      .s_tdata_o       (wr_tdata),
      .s_tready_i      (wr_tready)
   );

   axi_burst_writer writer_i (
      .clk_i      (clk_i),
      .reset_i    (reset_i),
      .cmd        (cmd_if.writer),
      .s_tvalid_i (wr_tvalid),
      .s_tdata_i  (wr_tdata),
      .s_tready_o (wr_tready),
      .awaddr_o   (awaddr_o),
      .awlen_o    (awlen_o),
      .awsize_o   (awsize_o),
      .awburst_o  (awburst_o),
      .awvalid_o  (awvalid_o),
      .awready_i  (awready_i),
      .wdata_o    (wdata_o),
      .wstrb_o    (wstrb_o),
      .wlast_o    (wlast_o),
      .wvalid_o   (wvalid_o),
      .wready_i   (wready_i),
      .bresp_i    (bresp_i),
      .bvalid_i   (bvalid_i),
      .bready_o   (bready_o)
   );

endmodule

`default_nettype wire

// File: src/axis_axi_write.sv
// ==================================================
// Burst planner over the stream FIFO and prefetch
// Transfers must stay inside one 4 KB page
// ==================================================
`timescale 1ns/1ps
`default_nettype none

module axis_axi_write (
   input  wire logic                    clk_i,
   input  wire logic                    reset_i,
   input  wire logic                    start_i,
   input  wire axi_bus_pkg::addr_t      addr_i,
   input  wire wdma_ctrl_pkg::wlen_t    length_i,
   input  wire axi_bus_pkg::burst_len_t max_len_i,
   output logic                         busy_o,
   output wdma_ctrl_pkg::wlen_t         remaining_o,
   input  wire axi_bus_pkg::data_t      s_axis_tdata_i,
   input  wire logic                    s_axis_tvalid_i,
   output logic                         s_axis_tready_o,
   burst_cmd_if.planner                 cmd,
   output logic                         s_tvalid_o,
   output axi_bus_pkg::data_t           s_tdata_o,
   input  wire logic                    s_tready_i
);

   wdma_ctrl_pkg::plan_state_e state_q;
   wdma_ctrl_pkg::plan_state_e state_d;
   wdma_ctrl_pkg::wlen_t       remaining_q;
   wdma_ctrl_pkg::wlen_t       remaining_d;
   axi_bus_pkg::addr_t         burst_addr_q;
   axi_bus_pkg::addr_t         burst_addr_d;
   axi_bus_pkg::burst_len_t    max_len_q;
   axi_bus_pkg::burst_len_t    max_len_d;
   axi_bus_pkg::burst_len_t    burst_len;
   logic                       start_burst;

   axi_bus_pkg::burst_len_t    fifo_level;
   logic                       fifo_full;
   logic                       fifo_empty;
   logic                       fifo_read;
   axi_bus_pkg::data_t         fifo_rdata;
   logic [1:0]                 pf_level;
   axi_bus_pkg::level_t        level;

   assign s_axis_tready_o = !fifo_full;

   axis_fifo buffer_i (
      .clk_i     (clk_i),
      .reset_i   (reset_i),
      .w_en_i    (s_axis_tvalid_i && s_axis_tready_o),
      .w_data_i  (s_axis_tdata_i),
      .w_full_o  (fifo_full),
      .r_en_i    (fifo_read),
      .r_data_o  (fifo_rdata),
      .r_empty_o (fifo_empty),
      .level_o   (fifo_level)
   );

   fifo_to_axis prefetch_i (
      .clk_i        (clk_i),
      .reset_i      (reset_i),
      .fifo_empty_i (fifo_empty),
      .fifo_read_o  (fifo_read),
      .fifo_rdata_i (fifo_rdata),
      .tvalid_o     (s_tvalid_o),
      .tdata_o      (s_tdata_o),
      .tready_i     (s_tready_i),
      .level_o      (pf_level)
   );

   // All words buffered ahead of the writer
   assign level = axi_bus_pkg::level_t'(fifo_level) + axi_bus_pkg::level_t'(pf_level);

   always_comb begin
      state_d      = state_q;
      remaining_d  = remaining_q;
      burst_addr_d = burst_addr_q;
      max_len_d    = max_len_q;
      burst_len    = '0;
      start_burst  = 1'b0;
      case (state_q)
         wdma_ctrl_pkg::IDLE: begin
            if (start_i) begin
               remaining_d  = length_i;
               burst_addr_d = addr_i;
               max_len_d    = max_len_i;
               state_d      = wdma_ctrl_pkg::PLAN;
            end
         end
         default: begin
            if (!cmd.busy) begin
               if (remaining_q != '0) begin
                  if (remaining_q <= wdma_ctrl_pkg::wlen_t'(max_len_q) &&
                      wdma_ctrl_pkg::wlen_t'(level) >= remaining_q) begin
                     // Tail fits in one burst and is all buffered
                     burst_len = axi_bus_pkg::burst_len_t'(remaining_q);
                  end else if (level >= axi_bus_pkg::level_t'(max_len_q)) begin
                     burst_len = max_len_q;
                  end
                  if (burst_len != '0) begin
                     start_burst  = 1'b1;
                     remaining_d  = remaining_q - wdma_ctrl_pkg::wlen_t'(burst_len);
                     burst_addr_d = burst_addr_q +
                        (axi_bus_pkg::addr_t'(burst_len) << axi_bus_pkg::AXI_WORD_SHIFT);
                  end
               end else if (start_i) begin
                  // Back-to-back transfer, busy_o is already low here
                  remaining_d  = length_i;
                  burst_addr_d = addr_i;
                  max_len_d    = max_len_i;
               end else begin
                  state_d = wdma_ctrl_pkg::IDLE;
               end
            end
         end
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         state_q     <= wdma_ctrl_pkg::IDLE;
         remaining_q <= '0;
      end else begin
         state_q     <= state_d;
         remaining_q <= remaining_d;
      end
   end

   always_ff @(posedge clk_i) begin
      burst_addr_q <= burst_addr_d;
      max_len_q    <= max_len_d;
   end

   assign cmd.addr  = burst_addr_q;
   assign cmd.len   = burst_len;
   assign cmd.start = start_burst;

   // Drops as soon as the last burst is acknowledged
   assign busy_o      = (state_q == wdma_ctrl_pkg::PLAN) && (remaining_q != '0 || cmd.busy);
   assign remaining_o = remaining_q;

endmodule

`default_nettype wire

// File: src/axi_burst_writer.sv
// ==================================================
// Runs one AXI4 INCR burst per command, AW then W then B
// BRESP is taken but not checked
// ==================================================
`timescale 1ns/1ps
`default_nettype none

module axi_burst_writer (
   input  wire logic                  clk_i,
   input  wire logic                  reset_i,
   burst_cmd_if.writer                cmd,
   input  wire logic                  s_tvalid_i,
   input  wire axi_bus_pkg::data_t    s_tdata_i,
   output logic                       s_tready_o,
   output axi_bus_pkg::addr_t         awaddr_o,
   output axi_bus_pkg::axi_len_t      awlen_o,
   output axi_bus_pkg::axi_size_t     awsize_o,
   output axi_bus_pkg::axi_burst_t    awburst_o,
   output logic                       awvalid_o,
   input  wire logic                  awready_i,
   output axi_bus_pkg::data_t         wdata_o,
   output axi_bus_pkg::strb_t         wstrb_o,
   output logic                       wlast_o,
   output logic                       wvalid_o,
   input  wire logic                  wready_i,
   input  wire axi_bus_pkg::axi_resp_t bresp_i,
   input  wire logic                  bvalid_i,
   output logic                       bready_o
);

   typedef enum logic [1:0] {
      W_IDLE,
      W_ADDR,
      W_DATA,
      W_RESP
   } wr_state_e;

   wr_state_e               state_q;
   axi_bus_pkg::addr_t      addr_q;
   axi_bus_pkg::burst_len_t len_q;
   axi_bus_pkg::burst_len_t beats_left_q;
   logic                    w_beat;

   assign cmd.busy = state_q != W_IDLE;

   assign awaddr_o  = addr_q;
   assign awlen_o   = axi_bus_pkg::axi_len_t'(len_q - 1'b1);
   assign awsize_o  = axi_bus_pkg::AXI_SIZE_WORD;
   assign awburst_o = axi_bus_pkg::AXI_BURST_INCR;
   assign awvalid_o = state_q == W_ADDR;

   // Stream words pass straight onto W; the prefetch holds them stable
   assign wdata_o    = s_tdata_i;
   assign wstrb_o    = '1;
   assign wvalid_o   = (state_q == W_DATA) && s_tvalid_i;
   assign s_tready_o = (state_q == W_DATA) && wready_i;
   assign wlast_o    = (state_q == W_DATA) && (beats_left_q == 1);
   assign w_beat     = wvalid_o && wready_i;

   assign bready_o = state_q == W_RESP;

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         state_q <= W_IDLE;
      end else begin
         case (state_q)
            W_IDLE: if (cmd.start) state_q <= W_ADDR;
            W_ADDR: if (awready_i) state_q <= W_DATA;
            W_DATA: if (w_beat && wlast_o) state_q <= W_RESP;
            // Response code is not acted on
            W_RESP: if (bvalid_i) state_q <= W_IDLE;
            default: state_q <= W_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk_i) begin
      if (state_q == W_IDLE && cmd.start) begin
         addr_q       <= cmd.addr;
         len_q        <= cmd.len;
         beats_left_q <= cmd.len;
      end else if (w_beat) begin
         beats_left_q <= beats_left_q - 1'b1;
      end
   end

endmodule

`default_nettype wire

// File: src/fifo_to_axis.sv
// ==================================================
// Two-word prefetch from a registered-read FIFO
// FIFO word reaches tvalid_o two cycles after read
// ==================================================
`timescale 1ns/1ps
`default_nettype none

module fifo_to_axis (
   input  wire logic               clk_i,
   input  wire logic               reset_i,
   input  wire logic               fifo_empty_i,
   output logic                    fifo_read_o,
   input  wire axi_bus_pkg::data_t fifo_rdata_i,
   output logic                    tvalid_o,
   output axi_bus_pkg::data_t      tdata_o,
   input  wire logic               tready_i,
   output logic [1:0]              level_o
);

   axi_bus_pkg::data_t head_q;
   axi_bus_pkg::data_t tail_q;
   logic [1:0]         held_q;
   logic               pending_q;
   logic               pop;

   assign tvalid_o = held_q != 2'd0;
   assign tdata_o  = head_q;
   assign pop      = tvalid_o && tready_i;

   // Held words plus the read still in flight
   assign level_o = held_q + {1'b0, pending_q};

   // Read ahead whenever a slot frees up, counting this cycle's pop
   assign fifo_read_o = !fifo_empty_i && ((level_o - {1'b0, pop}) < 2'd2);

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         held_q    <= 2'd0;
         pending_q <= 1'b0;
      end else begin
         pending_q <= fifo_read_o;
         held_q    <= held_q + {1'b0, pending_q} - {1'b0, pop};
      end
   end

   always_ff @(posedge clk_i) begin
      if (pending_q) begin
         if (held_q == 2'd0 || (held_q == 2'd1 && pop)) begin
            head_q <= fifo_rdata_i;
         end else if (pop) begin
            // Full and draining
            head_q <= tail_q;
            tail_q <= fifo_rdata_i;
         end else begin
            tail_q <= fifo_rdata_i;
         end
      end else if (pop) begin
         head_q <= tail_q;
      end
   end

endmodule

`default_nettype wire

// File: src/axis_fifo.sv
// ==================================================
// Synchronous FIFO, 16 words, registered read data
// Writes when full and reads when empty are dropped
// ==================================================
`timescale 1ns/1ps
`default_nettype none

module axis_fifo (
   input  wire logic                    clk_i,
   input  wire logic                    reset_i,
   input  wire logic                    w_en_i,
   input  wire axi_bus_pkg::data_t      w_data_i,
   output logic                         w_full_o,
   input  wire logic                    r_en_i,
   output axi_bus_pkg::data_t           r_data_o,
   output logic                         r_empty_o,
   output axi_bus_pkg::burst_len_t      level_o
);

   axi_bus_pkg::data_t      mem [axi_bus_pkg::FIFO_DEPTH];
   axi_bus_pkg::fifo_ptr_t  wr_ptr_q;
   axi_bus_pkg::fifo_ptr_t  rd_ptr_q;
   axi_bus_pkg::burst_len_t count_q;
   logic                    do_write;
   logic                    do_read;

   assign w_full_o  = count_q == axi_bus_pkg::burst_len_t'(axi_bus_pkg::FIFO_DEPTH);
   assign r_empty_o = count_q == '0;
   assign level_o   = count_q;

   assign do_write = w_en_i && !w_full_o;
   assign do_read  = r_en_i && !r_empty_o;

   // Pointers wrap at the power-of-two depth
   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end else begin
         if (do_write) begin
            wr_ptr_q <= wr_ptr_q + 1'b1;
         end
         if (do_read) begin
            rd_ptr_q <= rd_ptr_q + 1'b1;
         end
         case ({do_write, do_read})
            2'b10:   count_q <= count_q + 1'b1;
            2'b01:   count_q <= count_q - 1'b1;
            default: count_q <= count_q;
         endcase
      end
   end

   always_ff @(posedge clk_i) begin
      if (do_write) begin
         mem[wr_ptr_q] <= w_data_i;
      end
   end

   // Read data valid the cycle after r_en_i
   always_ff @(posedge clk_i) begin
      if (do_read) begin
         r_data_o <= mem[rd_ptr_q];
      end
   end

endmodule

`default_nettype wire

// File: src/burst_cmd_if.sv
// ==================================================
// One burst request, planner to writer
// Start only while busy is low, len at least 1
// ==================================================
`timescale 1ns/1ps
`default_nettype none

interface burst_cmd_if (
   input wire logic clk_i
);

   axi_bus_pkg::addr_t      addr;
   axi_bus_pkg::burst_len_t len;
   logic                    start;
   logic                    busy;

   modport planner (input clk_i, output addr, output len, output start, input busy);
   modport writer  (input clk_i, input addr, input len, input start, output busy);

endinterface

`default_nettype wire

// File: src/wdma_ctrl_pkg.sv
// ==================================================
// Transfer control types for the stream writer
// Transfers are limited to 4095 words
// ==================================================
`default_nettype none

package wdma_ctrl_pkg;

   localparam int WLEN_W = 12;

   typedef logic [WLEN_W-1:0] wlen_t;

   // Planner waits for start, then slices bursts
   typedef enum logic {
      IDLE,
      PLAN
   } plan_state_e;

endpackage

`default_nettype wire

// File: src/axi_bus_pkg.sv
// ==================================================
// AXI4 write bus shape for 32-bit words
// Bursts of at most 16 beats, full strobes only
// ==================================================
`default_nettype none

package axi_bus_pkg;

   localparam int AXI_ADDR_W     = 32;
   localparam int AXI_DATA_W     = 32;
   localparam int AXI_LEN_W      = 4;
   localparam int AXI_STRB_W     = AXI_DATA_W / 8;
   localparam int AXI_WORD_SHIFT = 2;
   localparam int FIFO_DEPTH     = 1 << AXI_LEN_W;

   typedef logic [AXI_ADDR_W-1:0]  addr_t;
   typedef logic [AXI_DATA_W-1:0]  data_t;
   typedef logic [AXI_STRB_W-1:0]  strb_t;
   typedef logic [AXI_LEN_W:0]     burst_len_t;
   typedef logic [AXI_LEN_W+1:0]   level_t;
   typedef logic [AXI_LEN_W-1:0]   fifo_ptr_t;
   typedef logic [7:0]             axi_len_t;
   typedef logic [2:0]             axi_size_t;
   typedef logic [1:0]             axi_burst_t;
   typedef logic [1:0]             axi_resp_t;

   localparam axi_size_t  AXI_SIZE_WORD  = 3'b010;
   localparam axi_burst_t AXI_BURST_INCR = 2'b01;
   localparam axi_resp_t  AXI_RESP_OKAY  = 2'b00;

endpackage

`default_nettype wire
